//--- mem_test_config.svh
`ifndef MEM_TEST_CONFIG_SVH
`define MEM_TEST_CONFIG_SVH

// Number of SRAM chips on the board, striped word by word.
`define NUM_S 4

// Pin widths of one asynchronous SRAM chip.
`define SRAM_ADDR_WIDTH 18
`define SRAM_DATA_WIDTH 16

// One pass is NUM_BURSTS bursts of NUM_BEATS words each.
`define NUM_BURSTS 8
`define NUM_BEATS 32

// The chip is selected by the low log2(NUM_S) bits of a linear address.
`define STRIPE_BITS 2

`endif

//--- mem_types_pkg.sv
`include "mem_test_config.svh"

package mem_types_pkg;

  typedef enum logic {
    MEM_OP_WRITE,
    MEM_OP_READ
  } mem_op_t;

  // A linear address carries the stripe in its low bits.
  typedef struct packed {
    logic                                      valid;
    mem_op_t                                   op;
    logic [`SRAM_ADDR_WIDTH+`STRIPE_BITS-1:0] addr;
    logic [`SRAM_DATA_WIDTH-1:0]               data;
  } mem_req_t;

  typedef struct packed {
    logic                        valid;
    logic [`SRAM_DATA_WIDTH-1:0] data;
  } mem_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ,
    DRAIN,
    DONE
  } gen_state_t;

endpackage

//--- sram_pkg.sv
`include "mem_test_config.svh"

package sram_pkg;

  typedef struct packed {
    logic                        valid;
    mem_types_pkg::mem_op_t      op;
    logic [`SRAM_ADDR_WIDTH-1:0] addr;
    logic [`SRAM_DATA_WIDTH-1:0] data;
  } sram_req_t;

  // The data bus is split into out and in. data_oe marks when the board drives it.
  typedef struct packed {
    logic [`SRAM_ADDR_WIDTH-1:0] addr;
    logic [`SRAM_DATA_WIDTH-1:0] data_out;
    logic                        data_oe;
    logic                        we_n;
    logic                        oe_n;
    logic                        ce_n;
  } sram_pins_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RELEASE
  } ctrl_state_t;

endpackage

//--- mem_pattern_gen.sv
`timescale 1ns/1ns
`include "mem_test_config.svh"

module mem_pattern_gen (
  input  logic                    clk,
  input  logic                    rst_n,
  output mem_types_pkg::mem_req_t req,
  input  mem_types_pkg::mem_rsp_t rsp,
  output logic                    done,
  output logic                    pass
);

  localparam int LIN_W = `SRAM_ADDR_WIDTH + `STRIPE_BITS;
  localparam int DATA_W = `SRAM_DATA_WIDTH;
  localparam int BEAT_W = $clog2(`NUM_BEATS);
  localparam int BURST_W = $clog2(`NUM_BURSTS);
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [DATA_W-1:0] SEED = 16'hA5A5;

  mem_types_pkg::gen_state_t state;
  logic [3:0]                pass_num;
  logic [BURST_W-1:0]        burst;
  logic [BEAT_W-1:0]         beat;
  logic [LIN_W-1:0]          lin_addr;
  logic                      last_beat;
  logic                      last_burst;
  logic [DATA_W-1:0]         exp_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [PTR_W:0]            exp_count;
  logic                      exp_push;
  logic                      exp_pop;
  logic                      pass_q;

  // The seed rotated left by the pass number, XOR-ed with the address.
  function automatic logic [DATA_W-1:0] pattern(input logic [LIN_W-1:0] a,
                                                input logic [3:0] p);
    logic [2*DATA_W-1:0] dbl;
    dbl = {SEED, SEED} << p;
    return a[DATA_W-1:0] ^ dbl[2*DATA_W-1:DATA_W];
  endfunction

  assign lin_addr = LIN_W'(burst) * LIN_W'(`NUM_BEATS) + LIN_W'(beat);
  assign last_beat = (beat == BEAT_W'(`NUM_BEATS - 1));
  assign last_burst = (burst == BURST_W'(`NUM_BURSTS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= mem_types_pkg::IDLE;
      pass_num <= '0;
      burst <= '0;
      beat <= '0;
      req.valid <= 1'b0;
    end else begin
      req.valid <= 1'b0;
      case (state)
        mem_types_pkg::IDLE: state <= mem_types_pkg::WRITE;
        mem_types_pkg::WRITE, mem_types_pkg::READ: begin
          // Reads carry the expected word so it can enter the FIFO at issue.
          req.valid <= 1'b1;
          req.addr <= lin_addr;
          req.data <= pattern(lin_addr, pass_num);
          if (state == mem_types_pkg::WRITE) begin
            req.op <= mem_types_pkg::MEM_OP_WRITE;
          end else begin
            req.op <= mem_types_pkg::MEM_OP_READ;
          end
          if (last_beat) begin
            beat <= '0;
            if (state == mem_types_pkg::WRITE) begin
              state <= mem_types_pkg::READ;
            end else begin
              state <= mem_types_pkg::DRAIN;
            end
          end else begin
            beat <= beat + 1'b1;
          end
        end
        mem_types_pkg::DRAIN: begin
          if (exp_count == '0 && !req.valid) begin
            if (last_burst) begin
              burst <= '0;
              state <= mem_types_pkg::DONE;
            end else begin
              burst <= burst + 1'b1;
              state <= mem_types_pkg::WRITE;
            end
          end
        end
        mem_types_pkg::DONE: begin
          pass_num <= pass_num + 1'b1;
          state <= mem_types_pkg::WRITE;
        end
        default: state <= mem_types_pkg::IDLE;
      endcase
    end
  end

  assign exp_push = req.valid && (req.op == mem_types_pkg::MEM_OP_READ);
  assign exp_pop = rsp.valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      exp_count <= '0;
      pass_q <= 1'b1;
    end else begin
      if (exp_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (exp_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (exp_push && !exp_pop) begin
        exp_count <= exp_count + 1'b1;
      end else if (!exp_push && exp_pop) begin
        exp_count <= exp_count - 1'b1;
      end
      if (exp_pop && rsp.data != exp_mem[rd_ptr]) begin
        pass_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (exp_push) begin
      exp_mem[wr_ptr] <= req.data;
    end
  end

  assign done = (state == mem_types_pkg::DONE);
  assign pass = pass_q;

  // Every read that comes back must have been issued by this generator.
  a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.valid |-> exp_count != '0);

endmodule

//--- stripe_router.sv
`timescale 1ns/1ns
`include "mem_test_config.svh"

module stripe_router (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  mem_types_pkg::mem_req_t                   req,
  output mem_types_pkg::mem_rsp_t                   rsp,
  output sram_pkg::sram_req_t     [`NUM_S-1:0]      chip_req,
  input  mem_types_pkg::mem_rsp_t [`NUM_S-1:0]      chip_rsp
);

  // Cycles from a generator read to the matching controller response.
  localparam int TAG_DEPTH = 3;

  logic [`STRIPE_BITS-1:0]                 stripe;
  logic [`SRAM_ADDR_WIDTH-1:0]             chip_addr;
  logic [`NUM_S-1:0]                       rsp_valid;
  mem_types_pkg::mem_rsp_t                 merged;
  logic [TAG_DEPTH-1:0]                    tag_valid;
  logic [TAG_DEPTH-1:0][`STRIPE_BITS-1:0] tag_stripe;

  assign stripe = req.addr[`STRIPE_BITS-1:0];
  assign chip_addr = req.addr[`STRIPE_BITS +: `SRAM_ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_S; i++) begin
        chip_req[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < `NUM_S; i++) begin
        chip_req[i].valid <= req.valid && (stripe == `STRIPE_BITS'(i));
        if (stripe == `STRIPE_BITS'(i)) begin
          chip_req[i].op <= req.op;
          chip_req[i].addr <= chip_addr;
          chip_req[i].data <= req.data;
        end
      end
    end
  end

  // Idle controllers hold stale data, so only valid responses are merged.
  always_comb begin
    merged = '0;
    for (int i = 0; i < `NUM_S; i++) begin
      rsp_valid[i] = chip_rsp[i].valid;
      if (chip_rsp[i].valid) begin
        merged = merged | chip_rsp[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp.valid <= 1'b0;
      tag_valid <= '0;
    end else begin
      rsp.valid <= merged.valid;
      rsp.data <= merged.data;
      tag_valid <= {tag_valid[TAG_DEPTH-2:0],
                    req.valid && (req.op == mem_types_pkg::MEM_OP_READ)};
      tag_stripe <= {tag_stripe[TAG_DEPTH-2:0], stripe};
    end
  end

  a_one_chip_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(rsp_valid));

  // Each response comes from the chip of the read issued TAG_DEPTH cycles earlier.
  a_stripe_order: assert property (@(posedge clk) disable iff (!rst_n)
    ((|rsp_valid) == tag_valid[TAG_DEPTH-1]) &&
    (!tag_valid[TAG_DEPTH-1] || rsp_valid[tag_stripe[TAG_DEPTH-1]]));

endmodule

//--- sram_ctrl.sv
`timescale 1ns/1ns
`include "mem_test_config.svh"

module sram_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  sram_pkg::sram_req_t         req,
  output mem_types_pkg::mem_rsp_t     rsp,
  output sram_pkg::sram_pins_t        pins,
  input  logic [`SRAM_DATA_WIDTH-1:0] data_in
);

  sram_pkg::ctrl_state_t state;
  logic                  write;

  assign write = (req.op == mem_types_pkg::MEM_OP_WRITE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= sram_pkg::IDLE;
      pins.data_oe <= 1'b0;
      pins.we_n <= 1'b1;
      pins.oe_n <= 1'b1;
      pins.ce_n <= 1'b1;
      rsp.valid <= 1'b0;
    end else begin
      rsp.valid <= 1'b0;
      case (state)
        sram_pkg::IDLE: begin
          if (req.valid) begin
            state <= sram_pkg::ACCESS;
            pins.addr <= req.addr;
            pins.data_out <= req.data;
            pins.data_oe <= write;
            pins.we_n <= !write;
            pins.oe_n <= write;
            pins.ce_n <= 1'b0;
          end
        end
        sram_pkg::ACCESS: begin
          // Read data has settled by the end of the access cycle.
          state <= sram_pkg::RELEASE;
          pins.data_oe <= 1'b0;
          pins.we_n <= 1'b1;
          pins.oe_n <= 1'b1;
          pins.ce_n <= 1'b1;
          rsp.valid <= !pins.oe_n;
          rsp.data <= data_in;
        end
        sram_pkg::RELEASE: state <= sram_pkg::IDLE;
        default: state <= sram_pkg::IDLE;
      endcase
    end
  end

  // The stripe spacing must leave the controller idle before its next beat.
  a_req_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    req.valid |-> state == sram_pkg::IDLE);

  a_we_oe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(!pins.we_n && !pins.oe_n));

endmodule

//--- mem_test_striped_sram.sv
`timescale 1ns/1ns
`include "mem_test_config.svh"

module mem_test_striped_sram (
  input  logic                                       clk,
  input  logic                                       rst_n,
  output logic                                       done,
  output logic                                       pass,
  output sram_pkg::sram_pins_t [`NUM_S-1:0]          sram_pins,
  input  logic [`NUM_S-1:0][`SRAM_DATA_WIDTH-1:0]    sram_data_in
);

  mem_types_pkg::mem_req_t              gen_req;
  mem_types_pkg::mem_rsp_t              gen_rsp;
  sram_pkg::sram_req_t     [`NUM_S-1:0] chip_req;
  mem_types_pkg::mem_rsp_t [`NUM_S-1:0] chip_rsp;

  mem_pattern_gen i_gen (
    .clk  (clk),
    .rst_n(rst_n),
    .req  (gen_req),
    .rsp  (gen_rsp),
    .done (done),
    .pass (pass)
  );

  stripe_router i_router (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (gen_req),
    .rsp     (gen_rsp),
    .chip_req(chip_req),
    .chip_rsp(chip_rsp)
  );

  for (genvar i = 0; i < `NUM_S; i++) begin : g_ctrl
    sram_ctrl i_ctrl (
      .clk    (clk),
      .rst_n  (rst_n),
      .req    (chip_req[i]),
      .rsp    (chip_rsp[i]),
      .pins   (sram_pins[i]),
      .data_in(sram_data_in[i])
    );
  end

endmodule

//--- sram_model.sv
`timescale 1ns/1ns
`include "mem_test_config.svh"

module sram_model (
  input  logic                        clk,
  input  sram_pkg::sram_pins_t        pins,
  input  logic                        fault,
  output logic [`SRAM_DATA_WIDTH-1:0] data_in
);

  localparam int DEPTH = 1 << `SRAM_ADDR_WIDTH;

  logic [`SRAM_DATA_WIDTH-1:0] mem [DEPTH];
  logic [`SRAM_DATA_WIDTH-1:0] flip;

  // The pins only change on clock edges, so a write is stored at the edge that ends it.
  always @(posedge clk) begin
    if (!pins.ce_n && !pins.we_n && pins.data_oe) begin
      mem[pins.addr] <= pins.data_out;
    end
  end

  // A faulty chip returns its stored word with bit 0 inverted.
  assign flip = {{(`SRAM_DATA_WIDTH-1){1'b0}}, fault};

  // The chip drives data only while it is selected with its output enabled.
  assign data_in = (!pins.ce_n && !pins.oe_n) ? (mem[pins.addr] ^ flip) : '0;

endmodule

//--- mem_test_striped_sram_tb.sv
`timescale 1ns/1ns
`include "mem_test_config.svh"

module mem_test_striped_sram_tb;

  localparam int CLK_HALF = 20;
  localparam int RESET_CYCLES = 5;
  localparam int RUN_PASSES = 5;
  localparam int FAULT_AFTER = 3;
  localparam int PASS_CYCLES = 2 * (`NUM_BURSTS * (2 * `NUM_BEATS + 8));
  localparam int WATCHDOG_CYCLES = 4 * PASS_CYCLES;
  localparam logic [`SRAM_ADDR_WIDTH-1:0] CHIP_WORDS = `NUM_BURSTS * `NUM_BEATS / `NUM_S;

  logic                                   clk;
  logic                                   rst_n;
  logic                                   done;
  logic                                   pass;
  sram_pkg::sram_pins_t [`NUM_S-1:0]      sram_pins;
  logic [`NUM_S-1:0][`SRAM_DATA_WIDTH-1:0] sram_data_in;
  logic [`NUM_S-1:0]                      fault;
  logic                                   fault_2 = 1'b0;
  logic [`NUM_S-1:0]                      quiet;
  logic [`SRAM_DATA_WIDTH-1:0]            exp_data [`NUM_S];
  int                                     done_count = 0;
  int                                     mismatch_count = 0;
  int                                     failure_count = 0;

  // Expected word at linear address lin in pass pass_no.
  function automatic logic [`SRAM_DATA_WIDTH-1:0] pattern_word(input int unsigned lin,
                                                              input int unsigned pass_no);
    logic [`SRAM_DATA_WIDTH-1:0] key;
    key = 16'hA5A5;
    for (int k = 0; k < int'(pass_no % 16); k++) begin
      key = {key[`SRAM_DATA_WIDTH-2:0], key[`SRAM_DATA_WIDTH-1]};
    end
    return lin[`SRAM_DATA_WIDTH-1:0] ^ key;
  endfunction

  mem_test_striped_sram i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .done        (done),
    .pass        (pass),
    .sram_pins   (sram_pins),
    .sram_data_in(sram_data_in)
  );

  assign fault = {{(`NUM_S-3){1'b0}}, fault_2, 2'b00};

  for (genvar i = 0; i < `NUM_S; i++) begin : g_chip
    sram_model i_sram (
      .clk    (clk),
      .pins   (sram_pins[i]),
      .fault  (fault[i]),
      .data_in(sram_data_in[i])
    );

    assign quiet[i] = sram_pins[i].ce_n && sram_pins[i].we_n && sram_pins[i].oe_n &&
                      !sram_pins[i].data_oe;
    // Chip i holds linear address addr*NUM_S+i, and the pass number follows done pulses.
    assign exp_data[i] = pattern_word(int'(sram_pins[i].addr) * `NUM_S + i, done_count);

    a_write_data: assert property (@(posedge clk) disable iff (!rst_n)
      !sram_pins[i].we_n |-> sram_pins[i].data_out == exp_data[i])
      else begin
        mismatch_count++;
        $display("mismatch write_data chip %0d: expected %h, actual %h", i,
                 $sampled(exp_data[i]), $sampled(sram_pins[i].data_out));
      end

    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
      !sram_pins[i].ce_n |-> sram_pins[i].addr < CHIP_WORDS)
      else begin
        failure_count++;
        $display("Chip %0d was accessed at address %0d, beyond the tested range", i,
                 $sampled(sram_pins[i].addr));
      end

    a_ce_with_access: assert property (@(posedge clk) disable iff (!rst_n)
      (!sram_pins[i].we_n || !sram_pins[i].oe_n) |-> !sram_pins[i].ce_n)
      else begin
        failure_count++;
        $display("Chip %0d saw we_n or oe_n low without ce_n low", i);
      end
  end

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      done_count <= 0;
    end else if (done) begin
      done_count <= done_count + 1;
    end
  end

  // Chip 2 starts failing early in the fourth pass.
  always @(posedge clk) begin
    if (rst_n && done_count >= FAULT_AFTER) begin
      fault_2 <= 1'b1;
    end
  end

  a_reset_done: assert property (@(posedge clk) $rose(rst_n) |-> !done)
    else begin
      mismatch_count++;
      $display("mismatch reset_done: expected 0, actual %b", $sampled(done));
    end

  a_reset_pass: assert property (@(posedge clk) $rose(rst_n) |-> pass)
    else begin
      mismatch_count++;
      $display("mismatch reset_pass: expected 1, actual %b", $sampled(pass));
    end

  a_reset_pins: assert property (@(posedge clk) $rose(rst_n) |-> quiet == '1)
    else begin
      mismatch_count++;
      $display("mismatch reset_pins: expected %b, actual %b", {`NUM_S{1'b1}}, $sampled(quiet));
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
      mismatch_count++;
      $display("mismatch done_pulse: expected 0, actual %b", $sampled(done));
    end

  a_pass_clean: assert property (@(posedge clk) disable iff (!rst_n)
    (done && done_count < FAULT_AFTER) |-> pass)
    else begin
      mismatch_count++;
      $display("mismatch pass_clean: expected 1, actual %b", $sampled(pass));
    end

  a_fault_seen: assert property (@(posedge clk) disable iff (!rst_n)
    (done && done_count >= FAULT_AFTER) |-> !pass)
    else begin
      mismatch_count++;
      $display("mismatch fault_seen: expected 0, actual %b", $sampled(pass));
    end

  a_pass_sticky: assert property (@(posedge clk) disable iff (!rst_n) !pass |=> !pass)
    else begin
      failure_count++;
      $display("The pass level rose again after it had fallen");
    end

  a_fall_after_fault: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(pass) |-> fault_2)
    else begin
      failure_count++;
      $display("The pass level fell before any fault was injected");
    end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    wait (done_count == RUN_PASSES);
    repeat (2) @(posedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d done pulses seen", WATCHDOG_CYCLES,
             done_count);
    $display("Something failed");
    $finish;
  end

endmodule

//--- mem_test_striped_sram.f
+incdir+.
mem_types_pkg.sv
sram_pkg.sv
mem_pattern_gen.sv
stripe_router.sv
sram_ctrl.sv
mem_test_striped_sram.sv
sram_model.sv
mem_test_striped_sram_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_test_striped_sram_tb
FILELIST  ?= mem_test_striped_sram.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= Everything OK

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := mem_test_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
